/* tb.f */
rtl/trace_pkg.sv
rtl/csr_snapshot_table.sv
rtl/commit_report.sv
rtl/store_tracker.sv
rtl/perf_counters.sv
rtl/apb_stat_regs.sv
rtl/commit_tracer_top.sv
sim/clk_gen.sv
sim/tb_commit_tracer.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_commit_tracer -f tb.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* sim/tb_commit_tracer.sv */
module tb_commit_tracer;
    timeunit 1ns;
    timeprecision 1ps;
    import trace_pkg::*;

    localparam int unsigned SEED = 32'h3bea_3347;
    localparam int CLK_PERIOD  = 8;
    localparam int RAND_CYCLES = 2500;  // two bursts plus apb reads come to about 5200 cycles
    localparam int MAX_CYCLES  = 8 * RAND_CYCLES; // about four times the test length

    logic clk;
    logic rst;
    logic dec_valid = 1'b0, com_valid = 1'b0, csr_we = 1'b0;
    opid_t dec_opid = '0, com_opid = '0;
    word_t csr_mstatus = '0, csr_mtvec = '0, csr_mepc = '0, csr_mcause = '0;
    word_t com_pc = '0, csr_wdata = '0, dc_addr = '0, dc_wdat = '0;
    instr_t com_ir = '0;
    gpr_addr_t com_rd = '0;
    csr_addr_t csr_addr = '0;
    logic dc_rqst_valid = 1'b0, dc_rqst_store = 1'b0, dc_resp_valid = 1'b0;
    logic dc_resp_store = 1'b0, dc_miss = 1'b0;
    store_tag_t dc_rqst_tag = '0, dc_resp_tag = '0;
    strb_t dc_strb = '0;
    logic mis_valid = 1'b0, mis_branch = 1'b0, mis_jal = 1'b0, mis_jalr = 1'b0;
    logic fe_redirect = 1'b0, ic_refill = 1'b0, dc_refill = 1'b0, ld_retry = 1'b0;
    logic psel = 1'b0, penable = 1'b0, pwrite = 1'b0;
    apb_addr_t paddr = '0;
    cnt_t pwdata = '0;
    cnt_t prdata;
    logic pready, pslverr, cmt, cmt_gpr, del_csrw;
    word_t cmt_pc, cmt_mstatus, cmt_mtvec, cmt_mepc, cmt_mcause;
    word_t del_csrv, del_mema, del_memv;
    instr_t cmt_ir;
    csr_addr_t del_csra;
    mem_size_t del_memw;

    logic [3:0][63:0] snap_m [128]; // mcause, mepc, mtvec, mstatus
    word_t slot_addr_m [16];
    word_t slot_data_m [16];
    mem_size_t slot_size_m [16];
    cnt_t cnt_m [NUM_CNT];
    logic exp_cmt, exp_gpr, exp_csrw, exp_resp;
    logic [3:0][63:0] exp_snap;
    word_t exp_pc, exp_csrv, exp_mema, exp_memv;
    instr_t exp_ir;
    csr_addr_t exp_csra;
    mem_size_t exp_memw;
    bit decoded [128];   // op ids that hold a snapshot
    bit requested [16];  // tags that hold a store
    int errors = 0;
    int cycle_cnt = 0;

    clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(10)) u_clk (.clk(clk), .rst(rst));

    commit_tracer_top uut (.*);

    function automatic csr_addr_t alias_ref(input csr_addr_t a);
        case (a)
            12'h100, 12'h104, 12'h144: return a + 12'h200; // sstatus, sie, sip
            12'hC00, 12'hC01, 12'hC02: return a - 12'h100; // cycle, time, instret
            default: return a;
        endcase
    endfunction

    function automatic int lowest_lane(input strb_t s);
        for (int i = 0; i < 8; i++) begin
            if (s[i]) return i;
        end
        return 0;
    endfunction

    function automatic mem_size_t byte_count(input strb_t s);
        mem_size_t n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            if (s[i]) n = n + 4'd1;
        end
        return n;
    endfunction

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic csr_addr_t pick_csr_addr();
        csr_addr_t list [9];
        list = '{12'h100, 12'h104, 12'h144, 12'hC00, 12'hC01, 12'hC02,
                 12'h300, 12'h101, 12'hC03};
        if ($urandom_range(0, 1) == 1) return list[$urandom_range(0, 8)];
        return csr_addr_t'($urandom);
    endfunction

    task automatic value_err(input string name, input logic [63:0] got, input logic [63:0] exp);
        errors++;
        $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
    endtask

    // reference model sees the same input values as the DUT at each edge
    always @(posedge clk) begin
        if (rst) begin
            exp_cmt <= 1'b0;
            exp_csrw <= 1'b0;
            exp_resp <= 1'b0;
            exp_memw <= '0;
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_m[i] <= '0;
            end
        end else begin
            exp_cmt <= com_valid;
            if (com_valid) begin
                exp_pc <= com_pc;
                exp_ir <= com_ir;
                exp_gpr <= (com_rd != 5'd0);
                exp_snap <= snap_m[com_opid]; // value before a same cycle decode
            end
            if (dec_valid) snap_m[dec_opid] <= {csr_mcause, csr_mepc, csr_mtvec, csr_mstatus};
            exp_csrw <= csr_we;
            if (csr_we) begin
                exp_csra <= alias_ref(csr_addr);
                exp_csrv <= csr_wdata;
            end
            if (dc_rqst_valid && dc_rqst_store) begin
                slot_addr_m[dc_rqst_tag] <= dc_addr;
                slot_data_m[dc_rqst_tag] <= dc_wdat >> (8 * lowest_lane(dc_strb));
                slot_size_m[dc_rqst_tag] <= byte_count(dc_strb);
            end
            exp_resp <= dc_resp_valid && dc_resp_store;
            exp_memw <= (dc_resp_valid && dc_resp_store && !dc_miss) ? slot_size_m[dc_resp_tag]
                                                                      : '0;
            if (dc_resp_valid && dc_resp_store) begin
                exp_mema <= slot_addr_m[dc_resp_tag];
                exp_memv <= slot_data_m[dc_resp_tag];
            end
            if (psel && penable && pwrite && paddr == 8'h40) begin
                for (int i = 0; i < NUM_CNT; i++) begin
                    cnt_m[i] <= '0; // clear beats events
                end
            end else begin
                if (mis_valid) begin
                    cnt_m[CNT_BMISP] <= cnt_m[CNT_BMISP] + 1;
                    if (mis_branch) cnt_m[CNT_BRMISP] <= cnt_m[CNT_BRMISP] + 1;
                    if (mis_jal) cnt_m[CNT_JMISP] <= cnt_m[CNT_JMISP] + 1;
                    if (mis_jalr) cnt_m[CNT_JRMISP] <= cnt_m[CNT_JRMISP] + 1;
                end else if (fe_redirect) begin
                    cnt_m[CNT_FMISP] <= cnt_m[CNT_FMISP] + 1;
                end
                if (dc_resp_valid && !dc_resp_store) cnt_m[CNT_LOADS] <= cnt_m[CNT_LOADS] + 1;
                if (dc_resp_valid && dc_resp_store) cnt_m[CNT_STORES] <= cnt_m[CNT_STORES] + 1;
                if (ic_refill) cnt_m[CNT_ICMISS] <= cnt_m[CNT_ICMISS] + 1;
                if (dc_refill) cnt_m[CNT_DCMISS] <= cnt_m[CNT_DCMISS] + 1;
                if (ld_retry) cnt_m[CNT_LDMISP] <= cnt_m[CNT_LDMISP] + 1;
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (cmt === exp_cmt) else value_err("cmt", 64'(cmt), 64'(exp_cmt));
            assert (del_csrw === exp_csrw)
                else value_err("del_csrw", 64'(del_csrw), 64'(exp_csrw));
            assert (del_memw === exp_memw)
                else value_err("del_memw", 64'(del_memw), 64'(exp_memw));
            if (exp_cmt) begin
                assert (cmt_pc === exp_pc) else value_err("cmt_pc", cmt_pc, exp_pc);
                assert (cmt_ir === exp_ir) else value_err("cmt_ir", 64'(cmt_ir), 64'(exp_ir));
                assert (cmt_gpr === exp_gpr)
                    else value_err("cmt_gpr", 64'(cmt_gpr), 64'(exp_gpr));
                assert (cmt_mstatus === exp_snap[0])
                    else value_err("cmt_mstatus", cmt_mstatus, exp_snap[0]);
                assert (cmt_mtvec === exp_snap[1])
                    else value_err("cmt_mtvec", cmt_mtvec, exp_snap[1]);
                assert (cmt_mepc === exp_snap[2])
                    else value_err("cmt_mepc", cmt_mepc, exp_snap[2]);
                assert (cmt_mcause === exp_snap[3])
                    else value_err("cmt_mcause", cmt_mcause, exp_snap[3]);
            end
            if (exp_csrw) begin
                assert (del_csra === exp_csra)
                    else value_err("del_csra", 64'(del_csra), 64'(exp_csra));
                assert (del_csrv === exp_csrv) else value_err("del_csrv", del_csrv, exp_csrv);
            end
            if (exp_resp) begin
                assert (del_mema === exp_mema) else value_err("del_mema", del_mema, exp_mema);
                assert (del_memv === exp_memv) else value_err("del_memv", del_memv, exp_memv);
            end
            if (!(psel && penable)) begin
                assert (pslverr === 1'b0) else value_err("pslverr", 64'(pslverr), 64'd0);
            end
        end
    end

    task automatic random_cycle();
        opid_t dop;
        opid_t cop;
        store_tag_t qtag;
        store_tag_t rtag;
        int lo;
        int len;
        int kind;
        logic dv;
        logic cv;
        logic qv;
        logic qs;
        logic rv;
        logic rs;
        dop = opid_t'($urandom);
        cop = opid_t'($urandom);
        qtag = store_tag_t'($urandom);
        rtag = store_tag_t'($urandom);
        lo = $urandom_range(0, 7);
        len = $urandom_range(1, 8 - lo); // contiguous strobe
        kind = $urandom_range(0, 3);
        dv = ($urandom_range(0, 1) == 1);
        cv = decoded[cop] && ($urandom_range(0, 1) == 1);
        qv = ($urandom_range(0, 1) == 1);
        qs = ($urandom_range(0, 3) != 0);
        rv = ($urandom_range(0, 1) == 1);
        rs = rv && requested[rtag] && ($urandom_range(0, 3) != 0); // else a load response
        if (dv) decoded[dop] = 1'b1;
        if (qv && qs) requested[qtag] = 1'b1;
        @(posedge clk);
        dec_valid <= dv;
        dec_opid <= dop;
        csr_mstatus <= rand_word();
        csr_mtvec <= rand_word();
        csr_mepc <= rand_word();
        csr_mcause <= rand_word();
        com_valid <= cv;
        com_opid <= cop;
        com_pc <= rand_word();
        com_ir <= $urandom;
        com_rd <= (kind == 0) ? 5'd0 : gpr_addr_t'($urandom);
        csr_we <= ($urandom_range(0, 1) == 1);
        csr_addr <= pick_csr_addr();
        csr_wdata <= rand_word();
        dc_rqst_valid <= qv;
        dc_rqst_store <= qs;
        dc_rqst_tag <= qtag;
        dc_addr <= rand_word();
        dc_wdat <= rand_word();
        dc_strb <= strb_t'(((1 << len) - 1) << lo);
        dc_resp_valid <= rv;
        dc_resp_store <= rs;
        dc_resp_tag <= rtag;
        dc_miss <= ($urandom_range(0, 3) == 0);
        mis_valid <= ($urandom_range(0, 3) == 0);
        mis_branch <= (kind == 1);
        mis_jal <= (kind == 2);
        mis_jalr <= (kind == 3);
        fe_redirect <= ($urandom_range(0, 2) == 0); // overlaps mis_valid at times
        ic_refill <= ($urandom_range(0, 3) == 0);
        dc_refill <= ($urandom_range(0, 3) == 0);
        ld_retry <= ($urandom_range(0, 3) == 0);
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        dec_valid <= 1'b0;
        com_valid <= 1'b0;
        csr_we <= 1'b0;
        dc_rqst_valid <= 1'b0;
        dc_resp_valid <= 1'b0;
        mis_valid <= 1'b0;
        fe_redirect <= 1'b0;
        ic_refill <= 1'b0;
        dc_refill <= 1'b0;
        ld_retry <= 1'b0;
    endtask

    // one setup and one access cycle with pready always high
    task automatic apb_access(input logic wr, input apb_addr_t addr, input logic exp_err);
        cnt_t exp_rd;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= $urandom;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        exp_rd = exp_err ? '0 : cnt_m[addr[5:2]];
        assert (pready === 1'b1) else value_err("pready", 64'(pready), 64'd1);
        assert (pslverr === exp_err) else value_err("pslverr", 64'(pslverr), 64'(exp_err));
        if (!wr) begin
            assert (prdata === exp_rd) else value_err("prdata", 64'(prdata), 64'(exp_rd));
        end
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_counters();
        for (int i = 0; i < NUM_CNT; i++) begin
            apb_access(1'b0, apb_addr_t'(4 * i), 1'b0);
        end
    endtask

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        while (rst !== 1'b0) @(posedge clk);
        read_counters(); // all zero out of reset
        repeat (RAND_CYCLES) random_cycle();
        idle_inputs();
        read_counters();
        apb_access(1'b1, APB_CLEAR_ADDR, 1'b0);
        read_counters();
        // clear lands on a cycle with live events
        fork
            repeat (4) random_cycle();
            apb_access(1'b1, APB_CLEAR_ADDR, 1'b0);
        join
        idle_inputs();
        read_counters();
        apb_access(1'b0, 8'h28, 1'b1); // index 10 is past the last counter
        apb_access(1'b0, 8'h06, 1'b1); // misaligned
        apb_access(1'b0, 8'h80, 1'b1);
        apb_access(1'b1, 8'h08, 1'b1); // counters are read only
        repeat (RAND_CYCLES) random_cycle();
        idle_inputs();
        read_counters();
        repeat (2) @(posedge clk);
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim/clk_gen.sv */
module clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0; // released on a rising edge
    end

endmodule

/* rtl/commit_tracer_top.sv */
module commit_tracer_top #(
    parameter int ROB_DEPTH   = 128,
    parameter int STORE_SLOTS = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dec_valid,
    input  trace_pkg::opid_t       dec_opid,
    input  trace_pkg::word_t       csr_mstatus,
    input  trace_pkg::word_t       csr_mtvec,
    input  trace_pkg::word_t       csr_mepc,
    input  trace_pkg::word_t       csr_mcause,
    input  logic                   com_valid,
    input  trace_pkg::opid_t       com_opid,
    input  trace_pkg::word_t       com_pc,
    input  trace_pkg::instr_t      com_ir,
    input  trace_pkg::gpr_addr_t   com_rd,
    input  logic                   csr_we,
    input  trace_pkg::csr_addr_t   csr_addr,
    input  trace_pkg::word_t       csr_wdata,
    input  logic                   dc_rqst_valid,
    input  logic                   dc_rqst_store,
    input  trace_pkg::store_tag_t  dc_rqst_tag,
    input  trace_pkg::word_t       dc_addr,
    input  trace_pkg::word_t       dc_wdat,
    input  trace_pkg::strb_t       dc_strb,
    input  logic                   dc_resp_valid,
    input  logic                   dc_resp_store,
    input  trace_pkg::store_tag_t  dc_resp_tag,
    input  logic                   dc_miss,
    input  logic                   mis_valid,
    input  logic                   mis_branch,
    input  logic                   mis_jal,
    input  logic                   mis_jalr,
    input  logic                   fe_redirect,
    input  logic                   ic_refill,
    input  logic                   dc_refill,
    input  logic                   ld_retry,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  trace_pkg::apb_addr_t   paddr,
    input  trace_pkg::cnt_t        pwdata,
    output trace_pkg::cnt_t        prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   cmt,
    output trace_pkg::word_t       cmt_pc,
    output trace_pkg::instr_t      cmt_ir,
    output logic                   cmt_gpr,
    output trace_pkg::word_t       cmt_mstatus,
    output trace_pkg::word_t       cmt_mtvec,
    output trace_pkg::word_t       cmt_mepc,
    output trace_pkg::word_t       cmt_mcause,
    output logic                   del_csrw,
    output trace_pkg::csr_addr_t   del_csra,
    output trace_pkg::word_t       del_csrv,
    output trace_pkg::mem_size_t   del_memw,
    output trace_pkg::word_t       del_mema,
    output trace_pkg::word_t       del_memv
);
    import trace_pkg::*;

    logic     cnt_clear; // apb write to the clear register
    cnt_idx_t cnt_idx;
    cnt_t     cnt_value;

    commit_report #(.ROB_DEPTH(ROB_DEPTH)) u_commit (
        .clk(clk), .rst(rst),
        .dec_valid(dec_valid), .dec_opid(dec_opid),
        .csr_mstatus(csr_mstatus), .csr_mtvec(csr_mtvec),
        .csr_mepc(csr_mepc), .csr_mcause(csr_mcause),
        .com_valid(com_valid), .com_opid(com_opid), .com_pc(com_pc),
        .com_ir(com_ir), .com_rd(com_rd),
        .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .cmt(cmt), .cmt_pc(cmt_pc), .cmt_ir(cmt_ir), .cmt_gpr(cmt_gpr),
        .cmt_mstatus(cmt_mstatus), .cmt_mtvec(cmt_mtvec),
        .cmt_mepc(cmt_mepc), .cmt_mcause(cmt_mcause),
        .del_csrw(del_csrw), .del_csra(del_csra), .del_csrv(del_csrv)
    );

    store_tracker #(.STORE_SLOTS(STORE_SLOTS)) u_store (
        .clk(clk), .rst(rst),
        .dc_rqst_valid(dc_rqst_valid), .dc_rqst_store(dc_rqst_store),
        .dc_rqst_tag(dc_rqst_tag), .dc_addr(dc_addr),
        .dc_wdat(dc_wdat), .dc_strb(dc_strb),
        .dc_resp_valid(dc_resp_valid), .dc_resp_store(dc_resp_store),
        .dc_resp_tag(dc_resp_tag), .dc_miss(dc_miss),
        .del_memw(del_memw), .del_mema(del_mema), .del_memv(del_memv)
    );

    perf_counters u_cnt (
        .clk(clk), .rst(rst), .clear(cnt_clear),
        .mis_valid(mis_valid), .mis_branch(mis_branch),
        .mis_jal(mis_jal), .mis_jalr(mis_jalr), .fe_redirect(fe_redirect),
        .dc_resp_valid(dc_resp_valid), .dc_resp_store(dc_resp_store),
        .ic_refill(ic_refill), .dc_refill(dc_refill), .ld_retry(ld_retry),
        .rd_idx(cnt_idx), .rd_value(cnt_value)
    );

    apb_stat_regs u_apb (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .clear(cnt_clear), .rd_idx(cnt_idx), .rd_value(cnt_value)
    );

endmodule

/* rtl/apb_stat_regs.sv */
module apb_stat_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  trace_pkg::apb_addr_t  paddr,
    input  trace_pkg::cnt_t       pwdata,
    output trace_pkg::cnt_t       prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  clear,
    output trace_pkg::cnt_idx_t   rd_idx,
    input  trace_pkg::cnt_t       rd_value
);
    import trace_pkg::*;

    typedef enum logic {
        APB_IDLE,
        APB_SETUP
    } apb_state_e;

    apb_state_e state_q;
    logic       access;
    logic       rd_ok;
    logic       clr_ok;

    // an access phase is only honoured right after a setup phase
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= APB_IDLE;
        end else if (psel && !penable) begin
            state_q <= APB_SETUP;
        end else begin
            state_q <= APB_IDLE; // pready is always high, access lasts one cycle
        end
    end

    assign access = psel && penable && (state_q == APB_SETUP);

    assign rd_idx = paddr[5:2];
    assign rd_ok  = !pwrite && (paddr[7:6] == 2'b00) && (paddr[1:0] == 2'b00)
                    && (32'(rd_idx) < NUM_CNT);
    assign clr_ok = pwrite && (paddr == APB_CLEAR_ADDR); // write data is don't care

    assign clear   = access && clr_ok;
    assign pready  = 1'b1;
    assign pslverr = access && !(rd_ok || clr_ok);
    assign prdata  = (access && rd_ok) ? rd_value : '0;

endmodule

/* rtl/perf_counters.sv */
module perf_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 mis_valid,
    input  logic                 mis_branch,
    input  logic                 mis_jal,
    input  logic                 mis_jalr,
    input  logic                 fe_redirect,
    input  logic                 dc_resp_valid,
    input  logic                 dc_resp_store,
    input  logic                 ic_refill,
    input  logic                 dc_refill,
    input  logic                 ld_retry,
    input  trace_pkg::cnt_idx_t  rd_idx,
    output trace_pkg::cnt_t      rd_value
);
    import trace_pkg::*;

    cnt_t               cnt_q [NUM_CNT];
    logic [NUM_CNT-1:0] inc;

    always_comb begin
        inc = '0;
        if (mis_valid) begin
            inc[CNT_BMISP] = 1'b1;
            if (mis_branch) inc[CNT_BRMISP] = 1'b1;
            if (mis_jal)    inc[CNT_JMISP]  = 1'b1;
            if (mis_jalr)   inc[CNT_JRMISP] = 1'b1;
        end else if (fe_redirect) begin
            inc[CNT_FMISP] = 1'b1; // hidden by a back-end flush
        end
        inc[CNT_LOADS]  = dc_resp_valid && !dc_resp_store;
        inc[CNT_STORES] = dc_resp_valid && dc_resp_store;
        inc[CNT_ICMISS] = ic_refill;
        inc[CNT_DCMISS] = dc_refill;
        inc[CNT_LDMISP] = ld_retry;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (inc[i]) cnt_q[i] <= cnt_q[i] + 1'b1; // wraps
            end
        end
    end

    // unmapped indices read as zero
    assign rd_value = (32'(rd_idx) < NUM_CNT) ? cnt_q[rd_idx] : '0;

endmodule

/* rtl/store_tracker.sv */
module store_tracker #(
    parameter int STORE_SLOTS = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dc_rqst_valid,
    input  logic                   dc_rqst_store,
    input  trace_pkg::store_tag_t  dc_rqst_tag,
    input  trace_pkg::word_t       dc_addr,
    input  trace_pkg::word_t       dc_wdat,
    input  trace_pkg::strb_t       dc_strb,
    input  logic                   dc_resp_valid,
    input  logic                   dc_resp_store,
    input  trace_pkg::store_tag_t  dc_resp_tag,
    input  logic                   dc_miss,
    output trace_pkg::mem_size_t   del_memw,
    output trace_pkg::word_t       del_mema,
    output trace_pkg::word_t       del_memv
);
    import trace_pkg::*;

    word_t     slot_addr [STORE_SLOTS];
    word_t     slot_data [STORE_SLOTS];
    mem_size_t slot_size [STORE_SLOTS];

    logic [2:0] strb_ofs; // lowest enabled byte lane
    logic       rqst_wr;
    logic       resp_st;
    logic       resp_hit;

    always_comb begin
        strb_ofs = '0;
        for (int i = 7; i >= 0; i--) begin
            if (dc_strb[i]) strb_ofs = 3'(i);
        end
    end

    assign rqst_wr  = dc_rqst_valid && dc_rqst_store && (32'(dc_rqst_tag) < STORE_SLOTS);
    assign resp_st  = dc_resp_valid && dc_resp_store;
    assign resp_hit = 32'(dc_resp_tag) < STORE_SLOTS;

    always_ff @(posedge clk) begin
        if (rqst_wr) begin
            slot_addr[dc_rqst_tag] <= dc_addr;
            slot_data[dc_rqst_tag] <= dc_wdat >> {strb_ofs, 3'b000}; // align to byte 0
            slot_size[dc_rqst_tag] <= mem_size_t'($countones(dc_strb));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            del_memw <= '0;
        end else if (resp_st && !dc_miss && resp_hit) begin
            del_memw <= slot_size[dc_resp_tag];
        end else begin
            del_memw <= '0; // miss or no store response
        end
    end

    always_ff @(posedge clk) begin
        if (resp_st && resp_hit) begin
            del_mema <= slot_addr[dc_resp_tag];
            del_memv <= slot_data[dc_resp_tag];
        end
    end

endmodule

/* rtl/commit_report.sv */
module commit_report #(
    parameter int ROB_DEPTH = 128
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  trace_pkg::opid_t      dec_opid,
    input  trace_pkg::word_t      csr_mstatus,
    input  trace_pkg::word_t      csr_mtvec,
    input  trace_pkg::word_t      csr_mepc,
    input  trace_pkg::word_t      csr_mcause,
    input  logic                  com_valid,
    input  trace_pkg::opid_t      com_opid,
    input  trace_pkg::word_t      com_pc,
    input  trace_pkg::instr_t     com_ir,
    input  trace_pkg::gpr_addr_t  com_rd,
    input  logic                  csr_we,
    input  trace_pkg::csr_addr_t  csr_addr,
    input  trace_pkg::word_t      csr_wdata,
    output logic                  cmt,
    output trace_pkg::word_t      cmt_pc,
    output trace_pkg::instr_t     cmt_ir,
    output logic                  cmt_gpr,
    output trace_pkg::word_t      cmt_mstatus,
    output trace_pkg::word_t      cmt_mtvec,
    output trace_pkg::word_t      cmt_mepc,
    output trace_pkg::word_t      cmt_mcause,
    output logic                  del_csrw,
    output trace_pkg::csr_addr_t  del_csra,
    output trace_pkg::word_t      del_csrv
);
    import trace_pkg::*;

    word_t snap_mstatus;
    word_t snap_mtvec;
    word_t snap_mepc;
    word_t snap_mcause;

    // map supervisor and user counter views onto machine addresses
    function automatic csr_addr_t alias_csr(input csr_addr_t a);
        if (a == CSR_SSTATUS || a == CSR_SIE || a == CSR_SIP)
            return a + CSR_SUP_OFS;
        else if (a >= CSR_CYCLE && a <= CSR_INSTRET)
            return a - CSR_CNT_OFS; // cycle, time, instret
        else
            return a;
    endfunction

    csr_snapshot_table #(.ROB_DEPTH(ROB_DEPTH)) u_snap (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_opid     (dec_opid),
        .csr_mstatus  (csr_mstatus),
        .csr_mtvec    (csr_mtvec),
        .csr_mepc     (csr_mepc),
        .csr_mcause   (csr_mcause),
        .rd_opid      (com_opid),
        .snap_mstatus (snap_mstatus),
        .snap_mtvec   (snap_mtvec),
        .snap_mepc    (snap_mepc),
        .snap_mcause  (snap_mcause)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            cmt      <= 1'b0;
            del_csrw <= 1'b0;
        end else begin
            cmt      <= com_valid;
            del_csrw <= csr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (com_valid) begin
            cmt_pc      <= com_pc;
            cmt_ir      <= com_ir;
            cmt_gpr     <= |com_rd; // x0 writes are not reported
            cmt_mstatus <= snap_mstatus;
            cmt_mtvec   <= snap_mtvec;
            cmt_mepc    <= snap_mepc;
            cmt_mcause  <= snap_mcause;
        end
        if (csr_we) begin
            del_csra <= alias_csr(csr_addr);
            del_csrv <= csr_wdata;
        end
    end

endmodule

/* rtl/csr_snapshot_table.sv */
module csr_snapshot_table #(
    parameter int ROB_DEPTH = 128
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dec_valid,
    input  trace_pkg::opid_t  dec_opid,
    input  trace_pkg::word_t  csr_mstatus,
    input  trace_pkg::word_t  csr_mtvec,
    input  trace_pkg::word_t  csr_mepc,
    input  trace_pkg::word_t  csr_mcause,
    input  trace_pkg::opid_t  rd_opid,
    output trace_pkg::word_t  snap_mstatus,
    output trace_pkg::word_t  snap_mtvec,
    output trace_pkg::word_t  snap_mepc,
    output trace_pkg::word_t  snap_mcause
);
    import trace_pkg::*;

    word_t mstatus_mem [ROB_DEPTH];
    word_t mtvec_mem   [ROB_DEPTH];
    word_t mepc_mem    [ROB_DEPTH];
    word_t mcause_mem  [ROB_DEPTH];

    logic wr_en;
    logic rd_hit;

    assign wr_en  = dec_valid && !rst && (32'(dec_opid) < ROB_DEPTH); // nothing captured in reset
    assign rd_hit = 32'(rd_opid) < ROB_DEPTH;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mstatus_mem[dec_opid] <= csr_mstatus;
            mtvec_mem[dec_opid]   <= csr_mtvec;
            mepc_mem[dec_opid]    <= csr_mepc;
            mcause_mem[dec_opid]  <= csr_mcause;
        end
    end

    // values the op saw when it was decoded
    assign snap_mstatus = rd_hit ? mstatus_mem[rd_opid] : '0;
    assign snap_mtvec   = rd_hit ? mtvec_mem[rd_opid]   : '0;
    assign snap_mepc    = rd_hit ? mepc_mem[rd_opid]    : '0;
    assign snap_mcause  = rd_hit ? mcause_mem[rd_opid]  : '0;

endmodule

/* rtl/trace_pkg.sv */
package trace_pkg;

    typedef logic [63:0] word_t;     // data, address, pc, csr value
    typedef logic [31:0] instr_t;    // instruction word
    typedef logic [6:0]  opid_t;     // reorder buffer op id
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  gpr_addr_t; // architectural rd index
    typedef logic [3:0]  store_tag_t;
    typedef logic [7:0]  strb_t;     // byte strobe of one word
    typedef logic [3:0]  mem_size_t; // bytes changed by a store
    typedef logic [31:0] cnt_t;      // counter and apb data
    typedef logic [7:0]  apb_addr_t;
    typedef logic [3:0]  cnt_idx_t;

    localparam int NUM_CNT = 10;

    // counter map, apb byte address is four times the index
    localparam cnt_idx_t CNT_BMISP  = 4'd0; // back-end mispredictions
    localparam cnt_idx_t CNT_BRMISP = 4'd1; // branch
    localparam cnt_idx_t CNT_JMISP  = 4'd2; // jal
    localparam cnt_idx_t CNT_JRMISP = 4'd3; // jalr
    localparam cnt_idx_t CNT_FMISP  = 4'd4; // front-end redirects
    localparam cnt_idx_t CNT_LOADS  = 4'd5;
    localparam cnt_idx_t CNT_STORES = 4'd6;
    localparam cnt_idx_t CNT_ICMISS = 4'd7; // icache refills
    localparam cnt_idx_t CNT_DCMISS = 4'd8; // dcache refills
    localparam cnt_idx_t CNT_LDMISP = 4'd9; // load replays

    localparam apb_addr_t APB_CLEAR_ADDR = 8'h40; // write clears all counters

    // csr addresses that get aliased in the write report
    localparam csr_addr_t CSR_SSTATUS = 12'h100;
    localparam csr_addr_t CSR_SIE     = 12'h104;
    localparam csr_addr_t CSR_SIP     = 12'h144;
    localparam csr_addr_t CSR_CYCLE   = 12'hC00; // first user counter
    localparam csr_addr_t CSR_INSTRET = 12'hC02; // last user counter, time sits between

    // supervisor to machine and user counter to machine counter offsets
    localparam csr_addr_t CSR_SUP_OFS = 12'h200;
    localparam csr_addr_t CSR_CNT_OFS = 12'h100;

endpackage
